//--- cps_mem_cfg.svh
// Bank geometry, client address widths, region bases and burst sizes
`ifndef CPS_MEM_CFG_SVH
`define CPS_MEM_CFG_SVH

// Bank word address and data widths
`define MEM_AW      22
`define MEM_DW      16

// Client address widths, the sound port includes its byte bit
`define MAIN_AW     19
`define SND_AW      17
`define GFX_AW      20

// Word offsets of each client region in the bank
`define MAIN_BASE   22'h00_0000
`define SND_BASE    22'h08_0000
`define GFX_BASE    22'h10_0000

// Words fetched per cache fill
`define ROM_BURST   1
`define GFX_BURST   2

`endif

//--- cps_mem_pkg.sv
// Bank request and response structs, bus owner enum and loader state enum
`include "cps_mem_cfg.svh"

package cps_mem_pkg;

    // Request toward the bank, held until ack
    typedef struct packed {
        logic                     rd;
        logic                     wr;
        logic [`MEM_AW-1:0]       addr;
        logic                     len;    // words minus one
        logic [`MEM_DW-1:0]       din;
        logic [`MEM_DW/8-1:0]     mask;   // active low byte enables
    } mem_req_t;

    // Response from the bank
    typedef struct packed {
        logic                     ack;
        logic                     dok;
        logic [`MEM_DW-1:0]       data;
    } mem_rsp_t;

    // Current holder of the bank
    typedef enum logic [2:0] {
        OWN_NONE,
        OWN_LOAD,
        OWN_MAIN,
        OWN_SND,
        OWN_GFX
    } bus_owner_e;

    // Download loader
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WAIT,
        LD_WRITE,
        LD_DONE
    } load_state_e;

endpackage

//--- rom_slot.sv
// Client ROM port with a one-entry cache that fetches misses from the bank
`timescale 1ns/1ns
`include "cps_mem_cfg.svh"

module rom_slot import cps_mem_pkg::*; #(
    parameter int                 DW   = 16,
    parameter int                 AW   = 20,
    parameter logic [`MEM_AW-1:0] BASE = '0
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    input  mem_rsp_t      req_rsp,
    output logic          ok,
    output logic [DW-1:0] data,
    output mem_req_t      req
);

// Byte ports carry the byte select in addr[0]
localparam int   WAW = (DW == 8) ? AW - 1 : AW;
localparam int   CW  = (DW == 32) ? 32 : 16;
localparam int   MAW = `MEM_AW;
localparam logic LEN = (DW == 32) ? 1'(`GFX_BURST - 1) : 1'(`ROM_BURST - 1);

logic [WAW-1:0] word_addr;
logic [WAW-1:0] cache_addr;
logic [WAW-1:0] fetch_addr;
logic [CW-1:0]  cache_data;
logic [DW-1:0]  data_sel;
logic           cache_valid;
logic           hit;
logic           busy;
logic           rd;
logic           word_cnt;

assign word_addr = addr[AW-1:AW-WAW];
assign hit       = cache_valid && cache_addr == word_addr;

generate
    if (DW == 8) begin : g_byte
        assign data_sel = addr[0] ? cache_data[15:8] : cache_data[7:0];
    end else begin : g_word
        assign data_sel = cache_data;
    end
endgenerate

always_ff @(posedge clk) begin
    if (rst) begin
        ok          <= 1'b0;
        cache_valid <= 1'b0;
        busy        <= 1'b0;
        rd          <= 1'b0;
        word_cnt    <= 1'b0;
    end else begin
        ok <= cs && hit;
        // Miss starts a fetch, the cache stays invalid until it is complete
        if (!busy && cs && !hit) begin
            busy        <= 1'b1;
            rd          <= 1'b1;
            cache_valid <= 1'b0;
            word_cnt    <= 1'b0;
        end
        if (req_rsp.ack) begin
            rd <= 1'b0;
        end
        if (busy && req_rsp.dok) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == LEN) begin
                busy        <= 1'b0;
                cache_valid <= 1'b1;
            end
        end
    end
end

// Cache payload and fetch address
always_ff @(posedge clk) begin
    if (!busy && cs && !hit) begin
        fetch_addr <= word_addr;
    end
    if (busy && req_rsp.dok) begin
        cache_addr <= fetch_addr;
        // First word is the low half
        if (word_cnt == 1'b0) begin
            cache_data[15:0] <= req_rsp.data;
        end else begin
            cache_data[CW-1 -: 16] <= req_rsp.data;
        end
    end
    data <= data_sel;
end

always_comb begin
    req      = '0;
    req.rd   = rd;
    req.addr = BASE + MAW'(fetch_addr);
    req.len  = LEN;
    req.mask = 2'b11;
end

endmodule

//--- bank_arbiter.sv
// Bank arbiter with loader priority, round-robin among slots and burst tracking
`timescale 1ns/1ns

module bank_arbiter import cps_mem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  mem_req_t   load_req,
    input  mem_req_t   main_req,
    input  mem_req_t   snd_req,
    input  mem_req_t   gfx_req,
    input  mem_rsp_t   bank_rsp,
    output mem_rsp_t   load_rsp,
    output mem_rsp_t   main_rsp,
    output mem_rsp_t   snd_rsp,
    output mem_rsp_t   gfx_rsp,
    output mem_req_t   bank_req,
    output bus_owner_e owner
);

mem_req_t   slot_req [3];
logic [2:0] slot_rq;
logic [1:0] last_idx;
logic [1:0] pick_idx;
logic       pick_any;
bus_owner_e pick_owner;
logic       pick_len;
logic       len_q;
logic       dok_cnt;
logic       release_bus;

// Slot order is main, sound, graphics
assign slot_req[0] = main_req;
assign slot_req[1] = snd_req;
assign slot_req[2] = gfx_req;
assign slot_rq = {gfx_req.rd | gfx_req.wr, snd_req.rd | snd_req.wr, main_req.rd | main_req.wr};

// Nearest requester after the last slot served
always_comb begin
    int idx;
    pick_any = 1'b0;
    pick_idx = last_idx;
    for (int i = 3; i >= 1; i--) begin
        idx = (int'(last_idx) + i) % 3;
        if (slot_rq[idx]) begin
            pick_any = 1'b1;
            pick_idx = 2'(idx);
        end
    end
end

always_comb begin
    pick_owner = OWN_NONE;
    pick_len   = 1'b0;
    if (load_req.rd || load_req.wr) begin
        pick_owner = OWN_LOAD;
        pick_len   = load_req.len;
    end else if (pick_any) begin
        case (pick_idx)
            2'd0:    pick_owner = OWN_MAIN;
            2'd1:    pick_owner = OWN_SND;
            default: pick_owner = OWN_GFX;
        endcase
        pick_len = slot_req[pick_idx].len;
    end
end

always_comb begin
    case (owner)
        OWN_LOAD: bank_req = load_req;
        OWN_MAIN: bank_req = main_req;
        OWN_SND:  bank_req = snd_req;
        OWN_GFX:  bank_req = gfx_req;
        default:  bank_req = '0;
    endcase
end

// Write ends on ack, read ends on its last dok
assign release_bus = (bank_rsp.ack && bank_req.wr) || (bank_rsp.dok && dok_cnt == len_q);

always_ff @(posedge clk) begin
    if (rst) begin
        owner    <= OWN_NONE;
        last_idx <= 2'd2;
        len_q    <= 1'b0;
        dok_cnt  <= 1'b0;
    end else if (owner == OWN_NONE) begin
        owner   <= pick_owner;
        len_q   <= pick_len;
        dok_cnt <= 1'b0;
        if (pick_owner inside {OWN_MAIN, OWN_SND, OWN_GFX}) begin
            last_idx <= pick_idx;
        end
    end else begin
        if (bank_rsp.dok) begin
            dok_cnt <= dok_cnt + 1'b1;
        end
        if (release_bus) begin
            owner <= OWN_NONE;
        end
    end
end

function automatic mem_rsp_t route(mem_rsp_t rsp, bus_owner_e cur, bus_owner_e who);
    mem_rsp_t r;
    r     = rsp;
    r.ack = rsp.ack && cur == who;
    r.dok = rsp.dok && cur == who;
    return r;
endfunction

assign load_rsp = route(bank_rsp, owner, OWN_LOAD);
assign main_rsp = route(bank_rsp, owner, OWN_MAIN);
assign snd_rsp  = route(bank_rsp, owner, OWN_SND);
assign gfx_rsp  = route(bank_rsp, owner, OWN_GFX);

endmodule

//--- rom_loader.sv
// Download loader turning ioctl bytes into masked bank writes
`timescale 1ns/1ns
`include "cps_mem_cfg.svh"

module rom_loader import cps_mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    input  mem_rsp_t    rsp,
    output mem_req_t    req,
    output logic        dwnld_busy
);

load_state_e      state;
logic [`MEM_AW:0] buf_addr;
logic [`MEM_AW:0] src_addr;
logic [7:0]       buf_dout;
logic [7:0]       src_dout;
logic             buf_valid;
logic [`MEM_AW-1:0] wr_addr;
logic [7:0]       wr_byte;
logic             wr_odd;
logic             wr_q;
logic             take;
logic             direct;
logic             use_buf;

// Bytes beyond the bank are dropped
assign take    = ioctl_wr && downloading && ioctl_addr[24:`MEM_AW+1] == '0;
assign direct  = state == LD_WAIT && !buf_valid && take;
assign use_buf = state == LD_WAIT && buf_valid;

assign src_addr = buf_valid ? buf_addr : ioctl_addr[`MEM_AW:0];
assign src_dout = buf_valid ? buf_dout : ioctl_dout;

always_ff @(posedge clk) begin
    if (rst) begin
        state      <= LD_IDLE;
        buf_valid  <= 1'b0;
        wr_q       <= 1'b0;
        dwnld_busy <= 1'b0;
    end else begin
        if (take && !direct) begin
            buf_valid <= 1'b1;
        end else if (use_buf) begin
            buf_valid <= 1'b0;
        end
        case (state)
            LD_IDLE: begin
                if (downloading) begin
                    dwnld_busy <= 1'b1;
                    state      <= LD_WAIT;
                end
            end
            LD_WAIT: begin
                if (buf_valid || take) begin
                    wr_q  <= 1'b1;
                    state <= LD_WRITE;
                end else if (!downloading) begin
                    dwnld_busy <= 1'b0;
                    state      <= LD_DONE;
                end
            end
            LD_WRITE: begin
                if (rsp.ack) begin
                    wr_q <= 1'b0;
                    if (!downloading && !buf_valid && !take) begin
                        dwnld_busy <= 1'b0;
                        state      <= LD_DONE;
                    end else begin
                        state <= LD_WAIT;
                    end
                end
            end
            default: state <= LD_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (take && !direct) begin
        buf_addr <= ioctl_addr[`MEM_AW:0];
        buf_dout <= ioctl_dout;
    end
    if (direct || use_buf) begin
        wr_addr <= src_addr[`MEM_AW:1];
        wr_byte <= src_dout;
        wr_odd  <= src_addr[0];
    end
end

always_comb begin
    req      = '0;
    req.wr   = wr_q;
    req.addr = wr_addr;
    req.din  = {2{wr_byte}};
    // Even address writes the low byte
    req.mask = {~wr_odd, wr_odd};
end

endmodule

//--- cps_mem_top.sv
// Memory access top joining the client slots, the loader and the arbiter
`timescale 1ns/1ns
`include "cps_mem_cfg.svh"

module cps_mem_top import cps_mem_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // Download
    input  logic                downloading,
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    input  logic                ioctl_wr,
    output logic                dwnld_busy,
    // Main CPU ROM
    input  logic                main_cs,
    input  logic [`MAIN_AW-1:0] main_addr,
    output logic                main_ok,
    output logic [15:0]         main_data,
    // Sound CPU ROM
    input  logic                snd_cs,
    input  logic [`SND_AW-1:0]  snd_addr,
    output logic                snd_ok,
    output logic [7:0]          snd_data,
    // Graphics ROM
    input  logic                gfx_cs,
    input  logic [`GFX_AW-1:0]  gfx_addr,
    output logic                gfx_ok,
    output logic [31:0]         gfx_data,
    // SDRAM bank
    output mem_req_t            bank_req,
    input  mem_rsp_t            bank_rsp
);

mem_req_t load_req, main_req, snd_req, gfx_req;
mem_rsp_t load_rsp, main_rsp, snd_rsp, gfx_rsp;

rom_slot #(.DW(16), .AW(`MAIN_AW), .BASE(`MAIN_BASE)) u_main (
    .clk     ( clk       ),
    .rst     ( rst       ),
    .cs      ( main_cs   ),
    .addr    ( main_addr ),
    .req_rsp ( main_rsp  ),
    .ok      ( main_ok   ),
    .data    ( main_data ),
    .req     ( main_req  )
);

rom_slot #(.DW(8), .AW(`SND_AW), .BASE(`SND_BASE)) u_snd (
    .clk     ( clk       ),
    .rst     ( rst       ),
    .cs      ( snd_cs    ),
    .addr    ( snd_addr  ),
    .req_rsp ( snd_rsp   ),
    .ok      ( snd_ok    ),
    .data    ( snd_data  ),
    .req     ( snd_req   )
);

rom_slot #(.DW(32), .AW(`GFX_AW), .BASE(`GFX_BASE)) u_gfx (
    .clk     ( clk       ),
    .rst     ( rst       ),
    .cs      ( gfx_cs    ),
    .addr    ( gfx_addr  ),
    .req_rsp ( gfx_rsp   ),
    .ok      ( gfx_ok    ),
    .data    ( gfx_data  ),
    .req     ( gfx_req   )
);

rom_loader u_loader (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .downloading ( downloading ),
    .ioctl_addr  ( ioctl_addr  ),
    .ioctl_dout  ( ioctl_dout  ),
    .ioctl_wr    ( ioctl_wr    ),
    .rsp         ( load_rsp    ),
    .req         ( load_req    ),
    .dwnld_busy  ( dwnld_busy  )
);

bank_arbiter u_arbiter (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .load_req ( load_req ),
    .main_req ( main_req ),
    .snd_req  ( snd_req  ),
    .gfx_req  ( gfx_req  ),
    .bank_rsp ( bank_rsp ),
    .load_rsp ( load_rsp ),
    .main_rsp ( main_rsp ),
    .snd_rsp  ( snd_rsp  ),
    .gfx_rsp  ( gfx_rsp  ),
    .bank_req ( bank_req ),
    .owner    (          )
);

endmodule

//--- tb_sdram_model.sv
// Behavioural SDRAM bank with random ack and dok delays and a byte-masked memory
`timescale 1ns/1ns
`include "cps_mem_cfg.svh"

module tb_sdram_model import cps_mem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t req,
    output mem_rsp_t rsp
);

// Sparse word storage, untouched words read back a fill pattern
logic [15:0] mem [int];

int                 phase;      // 0 idle, 1 ack delay, 2 read data
int                 wait_cnt;
int                 words_left;
logic               is_rd;
logic [`MEM_AW-1:0] cur_addr;

function automatic logic [15:0] read_word(int a);
    if (mem.exists(a)) begin
        return mem[a];
    end
    return 16'(a) ^ 16'(a >> 7) ^ 16'h3c5a;
endfunction

always @(posedge clk) begin
    logic [15:0] w;
    if (rst) begin
        rsp        <= '0;
        phase      <= 0;
        wait_cnt   <= 0;
        words_left <= 0;
        is_rd      <= 1'b0;
    end else begin
        rsp.ack <= 1'b0;
        rsp.dok <= 1'b0;
        case (phase)
            0: begin
                // Request still visible on its own ack edge is not a new one
                if ((req.rd || req.wr) && !rsp.ack) begin
                    cur_addr   <= req.addr;
                    words_left <= int'(req.len) + 1;
                    is_rd      <= req.rd;
                    wait_cnt   <= int'($urandom % 4);
                    phase      <= 1;
                    if (req.wr) begin
                        w = read_word(int'(req.addr));
                        if (!req.mask[0]) begin
                            w[7:0] = req.din[7:0];
                        end
                        if (!req.mask[1]) begin
                            w[15:8] = req.din[15:8];
                        end
                        mem[int'(req.addr)] = w;
                    end
                end
            end
            1: begin
                if (wait_cnt == 0) begin
                    rsp.ack  <= 1'b1;
                    wait_cnt <= int'($urandom % 3);
                    phase    <= is_rd ? 2 : 0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
            default: begin
                if (wait_cnt == 0) begin
                    rsp.dok    <= 1'b1;
                    rsp.data   <= read_word(int'(cur_addr));
                    cur_addr   <= cur_addr + 1'b1;
                    words_left <= words_left - 1;
                    wait_cnt   <= int'($urandom % 3);
                    if (words_left == 1) begin
                        phase <= 0;
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        endcase
    end
end

endmodule

//--- tb_cps_mem.sv
// Testbench top with clock, reset, download, random client reads, reference model and report
`timescale 1ns/1ns
`include "cps_mem_cfg.svh"

module tb_cps_mem import cps_mem_pkg::*; ();

localparam int C_MAIN     = 0;
localparam int C_SND      = 1;
localparam int C_GFX      = 2;
localparam int WIN_OFS    = 'h300;  // window start in words into each region
localparam int WIN_WORDS  = 32;
localparam int READS      = 40;
localparam int ROUNDS     = 12;
localparam int RD_TIMEOUT = 300;

logic                clk;
logic                rst;
logic                downloading;
logic [24:0]         ioctl_addr;
logic [7:0]          ioctl_dout;
logic                ioctl_wr;
logic                dwnld_busy;
logic                main_cs;
logic [`MAIN_AW-1:0] main_addr;
logic                main_ok;
logic [15:0]         main_data;
logic                snd_cs;
logic [`SND_AW-1:0]  snd_addr;
logic                snd_ok;
logic [7:0]          snd_data;
logic                gfx_cs;
logic [`GFX_AW-1:0]  gfx_addr;
logic                gfx_ok;
logic [31:0]         gfx_data;
mem_req_t            bank_req;
mem_rsp_t            bank_rsp;

// Downloaded image by byte address
logic [7:0] image [int];
int         rd_starts;
logic       rd_q;
int         checks;
int         errors;
int         tests_run;
int         tests_failed;
int         mark;

cps_mem_top u_dut (.*);

tb_sdram_model u_bank (
    .clk ( clk      ),
    .rst ( rst      ),
    .req ( bank_req ),
    .rsp ( bank_rsp )
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// Read bursts started on the bank port
always @(posedge clk) begin
    if (rst) begin
        rd_q      <= 1'b0;
        rd_starts <= 0;
    end else begin
        rd_q <= bank_req.rd;
        if (bank_req.rd && !rd_q) begin
            rd_starts <= rd_starts + 1;
        end
    end
end

function automatic string client_name(int who);
    case (who)
        C_MAIN:  return "main";
        C_SND:   return "snd";
        default: return "gfx";
    endcase
endfunction

function automatic logic client_ok(int who);
    case (who)
        C_MAIN:  return main_ok;
        C_SND:   return snd_ok;
        default: return gfx_ok;
    endcase
endfunction

function automatic logic [31:0] client_data(int who);
    case (who)
        C_MAIN:  return {16'h0, main_data};
        C_SND:   return {24'h0, snd_data};
        default: return gfx_data;
    endcase
endfunction

// Even byte is the low half of a bank word
function automatic logic [15:0] ref_word(int w);
    return {image[2 * w + 1], image[2 * w]};
endfunction

function automatic logic [31:0] expect_data(int who, int a);
    logic [15:0] w;
    case (who)
        C_MAIN: expect_data = {16'h0, ref_word(int'(`MAIN_BASE) + a)};
        C_SND: begin
            w = ref_word(int'(`SND_BASE) + (a >> 1));
            expect_data = {24'h0, a[0] ? w[15:8] : w[7:0]};
        end
        default: begin
            expect_data = {ref_word(int'(`GFX_BASE) + a + 1), ref_word(int'(`GFX_BASE) + a)};
        end
    endcase
endfunction

// Sound addresses carry the byte bit, graphics keeps room for its second word
function automatic int pick_addr(int who);
    case (who)
        C_MAIN:  return WIN_OFS + int'($urandom % WIN_WORDS);
        C_SND:   return 2 * WIN_OFS + int'($urandom % (2 * WIN_WORDS));
        default: return WIN_OFS + int'($urandom % (WIN_WORDS - 1));
    endcase
endfunction

task automatic drive_client(int who, logic cs, int a);
    case (who)
        C_MAIN: begin
            main_cs   <= cs;
            main_addr <= `MAIN_AW'(a);
        end
        C_SND: begin
            snd_cs   <= cs;
            snd_addr <= `SND_AW'(a);
        end
        default: begin
            gfx_cs   <= cs;
            gfx_addr <= `GFX_AW'(a);
        end
    endcase
endtask

task automatic release_client(int who);
    @(posedge clk);
    drive_client(who, 1'b0, 0);
endtask

task automatic check_value(string sig, int a, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
        $display("Fail %s at %h: got %h, expected %h", sig, a, got, exp);
        errors++;
    end
endtask

task automatic end_test(string name);
    tests_run++;
    if (errors == mark) begin
        $display("%-20s passed", name);
    end else begin
        tests_failed++;
        $display("%-20s failed with %0d errors", name, errors - mark);
    end
    mark = errors;
endtask

// Latency counts falling edges after the edge that sees cs and addr
task automatic read_client(int who, int a, output logic [31:0] d, output int lat);
    int n;
    n   = 0;
    lat = -1;
    d   = '0;
    @(posedge clk);
    drive_client(who, 1'b1, a);
    @(posedge clk);
    while (lat < 0 && n < RD_TIMEOUT) begin
        @(negedge clk);
        n++;
        if (client_ok(who)) begin
            lat = n;
            d   = client_data(who);
        end
    end
    if (lat < 0) begin
        $display("Timeout waiting for %s_ok at address %h", client_name(who), a);
        errors++;
    end
endtask

task automatic read_and_check(int who, int a);
    logic [31:0] d;
    int          lat;
    read_client(who, a, d, lat);
    if (lat > 0) begin
        check_value({client_name(who), "_data"}, a, d, expect_data(who, a));
    end
    release_client(who);
endtask

task automatic wait_busy(logic level, int limit);
    int n;
    n = 0;
    while (dwnld_busy !== level && n < limit) begin
        @(negedge clk);
        n++;
    end
    if (dwnld_busy !== level) begin
        $display("Timeout waiting for dwnld_busy to become %0d", level);
        errors++;
    end
endtask

// One byte every 8 to 11 cycles keeps at most one byte pending
task automatic download_region(int base_word);
    int         b;
    int         gap;
    logic [7:0] v;
    for (int i = 0; i < 2 * WIN_WORDS; i++) begin
        b        = 2 * (base_word + WIN_OFS) + i;
        v        = 8'($urandom);
        gap      = 8 + int'($urandom % 4);
        image[b] = v;
        @(posedge clk);
        ioctl_addr <= 25'(b);
        ioctl_dout <= v;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        repeat (gap - 2) @(posedge clk);
    end
endtask

task automatic concurrent_round();
    int          a    [3];
    logic [31:0] d    [3];
    bit          done [3];
    int          n;
    int          left;
    for (int c = 0; c < 3; c++) begin
        a[c]    = pick_addr(c);
        done[c] = 1'b0;
    end
    @(posedge clk);
    for (int c = 0; c < 3; c++) begin
        drive_client(c, 1'b1, a[c]);
    end
    @(posedge clk);
    n    = 0;
    left = 3;
    while (left > 0 && n < RD_TIMEOUT) begin
        @(negedge clk);
        n++;
        for (int c = 0; c < 3; c++) begin
            if (!done[c] && client_ok(c)) begin
                d[c]    = client_data(c);
                done[c] = 1'b1;
                left--;
            end
        end
    end
    for (int c = 0; c < 3; c++) begin
        if (done[c]) begin
            check_value({client_name(c), "_data"}, a[c], d[c], expect_data(c, a[c]));
        end else begin
            $display("Timeout waiting for %s_ok at address %h", client_name(c), a[c]);
            errors++;
        end
    end
    @(posedge clk);
    for (int c = 0; c < 3; c++) begin
        drive_client(c, 1'b0, 0);
    end
endtask

initial begin
    logic [31:0] d;
    int          a;
    int          lat;
    int          starts;
    a            = int'($urandom(92));
    rst          = 1'b1;
    downloading  = 1'b0;
    ioctl_addr   = '0;
    ioctl_dout   = '0;
    ioctl_wr     = 1'b0;
    main_cs      = 1'b0;
    main_addr    = '0;
    snd_cs       = 1'b0;
    snd_addr     = '0;
    gfx_cs       = 1'b0;
    gfx_addr     = '0;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    mark         = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    check_value("main_ok", 0, {31'h0, main_ok}, 32'h0);
    check_value("snd_ok", 0, {31'h0, snd_ok}, 32'h0);
    check_value("gfx_ok", 0, {31'h0, gfx_ok}, 32'h0);
    check_value("bank_req.rd", 0, {31'h0, bank_req.rd}, 32'h0);
    check_value("bank_req.wr", 0, {31'h0, bank_req.wr}, 32'h0);
    check_value("dwnld_busy", 0, {31'h0, dwnld_busy}, 32'h0);
    check_value("main cache_valid", 0, {31'h0, u_dut.u_main.cache_valid}, 32'h0);
    check_value("snd cache_valid", 0, {31'h0, u_dut.u_snd.cache_valid}, 32'h0);
    check_value("gfx cache_valid", 0, {31'h0, u_dut.u_gfx.cache_valid}, 32'h0);
    end_test("reset");

    @(posedge clk);
    downloading <= 1'b1;
    wait_busy(1'b1, 10);
    download_region(int'(`MAIN_BASE));
    download_region(int'(`SND_BASE));
    download_region(int'(`GFX_BASE));
    @(posedge clk);
    downloading <= 1'b0;
    wait_busy(1'b0, 50);
    foreach (image[b]) begin
        d = {16'h0, u_bank.mem[b >> 1]};
        check_value("bank byte", b, b[0] ? d[15:8] : d[7:0], {24'h0, image[b]});
    end
    end_test("download");

    for (int i = 0; i < READS; i++) begin
        read_and_check(C_MAIN, pick_addr(C_MAIN));
    end
    end_test("main reads");
    for (int i = 0; i < READS; i++) begin
        read_and_check(C_SND, pick_addr(C_SND));
    end
    end_test("sound byte select");
    for (int i = 0; i < READS; i++) begin
        read_and_check(C_GFX, pick_addr(C_GFX));
    end
    end_test("graphics burst");

    // Second read of the same word must hit, the other sound byte too
    for (int c = 0; c < 3; c++) begin
        a = pick_addr(c);
        read_and_check(c, a);
        starts = rd_starts;
        read_client(c, a, d, lat);
        check_value({client_name(c), "_ok latency"}, a, 32'(lat), 32'd1);
        check_value({client_name(c), "_data"}, a, d, expect_data(c, a));
        if (c == C_SND) begin
            release_client(c);
            read_client(c, a ^ 1, d, lat);
            check_value("snd_ok latency", a ^ 1, 32'(lat), 32'd1);
            check_value("snd_data", a ^ 1, d, expect_data(c, a ^ 1));
        end
        check_value("bank_req.rd count", a, 32'(rd_starts - starts), 32'd0);
        release_client(c);
    end
    end_test("cache hit");

    for (int i = 0; i < ROUNDS; i++) begin
        concurrent_round();
    end
    end_test("concurrent clients");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
        $display("Test OK");
    end else begin
        $display("Test FAILED");
    end
    $finish;
end

endmodule

//--- flist.f
+incdir+.
cps_mem_pkg.sv
rom_slot.sv
bank_arbiter.sv
rom_loader.sv
cps_mem_top.sv
tb_sdram_model.sv
tb_cps_mem.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_cps_mem
RTL_TOP    := cps_mem_top
FLIST      := flist.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Test OK

RTL_SRCS := cps_mem_pkg.sv rom_slot.sv bank_arbiter.sv rom_loader.sv cps_mem_top.sv
TB_SRCS  := tb_sdram_model.sv tb_cps_mem.sv
HDRS     := cps_mem_cfg.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(RTL_SRCS) $(TB_SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) +incdir+. $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
